// File: Makefile
# Verilator build and run for the IO platform

VERILATOR ?= verilator
TOP       ?= io_platform_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/io_platform_tb.sv
// IO platform testbench
// APB traffic against a shadow register map, rtc pulses and interrupt checks

`default_nettype none

module io_platform_tb
    import io_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GPIO_W          = 32;
    localparam int CLK_PERIOD      = 40;
    localparam int N_GPIO_WR       = 16;
    localparam int N_RTC           = 12;
    localparam int N_XFERS         = 2 * N_GPIO_WR + 24;
    localparam int N_PULSES        = N_RTC + 8;
    localparam int WATCHDOG_CYCLES = N_XFERS * 3 + N_PULSES * 10 + 200;

    logic              aclk;
    logic              reset;
    logic              psel;
    logic              penable;
    addr_t             paddr;
    logic              pwrite;
    data_t             pwdata;
    strb_t             pstrb;
    data_t             prdata;
    logic              pready;
    logic              pslverr;
    logic              rtc;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic              timer_irq;

    // Shadow copy of the register map
    data_t       shadow_out;
    data_t       shadow_in;
    logic [63:0] shadow_mtime;
    logic [63:0] shadow_cmp;

    int     data_errs   = 0;
    int     err_errs    = 0;
    int     ready_errs  = 0;
    int     gpio_errs   = 0;
    int     irq_errs    = 0;
    int     misc_errs   = 0;
    int     issued      = 0;
    int     completed   = 0;
    int     wait_cycles = 0;
    integer seed        = 32'hd962_008a;

    io_platform #(
        .GPIO_W          (GPIO_W),
        .RTC_SYNC_STAGES (2)
    ) i_dut (
        .aclk      (aclk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rtc       (rtc),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
        data_t mask;
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // Expected response of an access cycle after the given number of wait states
    function automatic apb_rsp_t ref_read(addr_t addr, logic write, int waited);
        apb_rsp_t r;
        r = '{rdata: '0, ready: 1'b0, err: 1'b0};
        case (addr[7:2])
            6'd0: r.rdata = shadow_out;
            6'd1: begin
                r.rdata = shadow_in;
                r.err   = write;
            end
            6'd2: r.rdata = shadow_mtime[31:0];
            6'd3: r.rdata = shadow_mtime[63:32];
            6'd4: r.rdata = shadow_cmp[31:0];
            6'd5: r.rdata = shadow_cmp[63:32];
            default: r.err = 1'b1;
        endcase
        // Writes and errors carry no data
        if (write || r.err) begin
            r.rdata = '0;
        end
        // Timer window inserts one wait state
        r.ready = (waited == ((addr >= 8'd8 && addr < 8'd24) ? 1 : 0));
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(addr_t addr, data_t got, data_t exp);
        if (got !== exp) begin
            $display("ERR prdata at %h: got %h, expected %h", addr, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_err(addr_t addr, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR pslverr at %h: got %h, expected %h", addr, got, exp);
            err_errs++;
        end
    endtask

    task automatic check_ready(addr_t addr, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR pready at %h: got %h, expected %h", addr, got, exp);
            ready_errs++;
        end
    endtask

    task automatic check_gpio(logic [GPIO_W-1:0] got, logic [GPIO_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR gpio_out: got %h, expected %h", got, exp);
            gpio_errs++;
        end
    endtask

    task automatic check_irq(logic got, logic exp);
        if (got !== exp) begin
            $display("ERR timer_irq: got %h, expected %h", got, exp);
            irq_errs++;
        end
    endtask

    // Sample late in the cycle, once inputs and registers have settled
    always @(negedge aclk) begin
        apb_rsp_t expected;
        #(CLK_PERIOD / 4);
        if (psel && penable) begin
            expected = ref_read(paddr, pwrite, wait_cycles);
            check_ready(paddr, pready, expected.ready);
            if (pready) begin
                check_data(paddr, prdata, expected.rdata);
                check_err(paddr, pslverr, expected.err);
                completed++;
                wait_cycles = 0;
            end else begin
                wait_cycles++;
            end
        end else begin
            // Idle bus and setup phase stay quiet
            check_ready(paddr, pready, 1'b0);
            check_err(paddr, pslverr, 1'b0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks, entered and left on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic apb_xfer(addr_t addr, logic write, data_t wdata, strb_t strb);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        @(negedge aclk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready) begin
            @(negedge aclk);
            #(CLK_PERIOD / 4);
        end
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
        issued++;
        if (write) begin
            case (addr[7:2])
                6'd0: shadow_out = merge_bytes(shadow_out, wdata, strb);
                6'd2: shadow_mtime[31:0] = merge_bytes(shadow_mtime[31:0], wdata, strb);
                6'd3: shadow_mtime[63:32] = merge_bytes(shadow_mtime[63:32], wdata, strb);
                6'd4: shadow_cmp[31:0] = merge_bytes(shadow_cmp[31:0], wdata, strb);
                6'd5: shadow_cmp[63:32] = merge_bytes(shadow_cmp[63:32], wdata, strb);
                default: ;
            endcase
        end
    endtask

    task automatic apb_write(addr_t addr, data_t wdata, strb_t strb);
        apb_xfer(addr, 1'b1, wdata, strb);
    endtask

    task automatic apb_read(addr_t addr);
        apb_xfer(addr, 1'b0, '0, '0);
    endtask

    // Pulses of 4 or 5 cycles high and low, then a settle gap
    task automatic rtc_pulses(int n);
        for (int i = 0; i < n; i++) begin
            rtc = 1'b1;
            repeat (4 + ($unsigned($random(seed)) % 2)) @(negedge aclk);
            rtc = 1'b0;
            repeat (4 + ($unsigned($random(seed)) % 2)) @(negedge aclk);
            shadow_mtime++;
        end
        repeat (8) @(negedge aclk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] base;
        data_t       hi_word;
        psel         = 1'b0;
        penable      = 1'b0;
        paddr        = '0;
        pwrite       = 1'b0;
        pwdata       = '0;
        pstrb        = '0;
        rtc          = 1'b0;
        gpio_in      = '0;
        reset        = 1'b1;
        shadow_out   = '0;
        shadow_in    = '0;
        shadow_mtime = '0;
        shadow_cmp   = '1;
        repeat (16) @(negedge aclk);
        reset = 1'b0;
        @(negedge aclk);

        // Reset values
        check_gpio(gpio_out, '0);
        check_irq(timer_irq, 1'b0);
        apb_read(timer_base + mtimecmp_lo);
        apb_read(timer_base + mtimecmp_hi);
        apb_read(timer_base + mtime_lo);

        // GPIO output under random strobes, held input
        gpio_in   = $random(seed);
        shadow_in = gpio_in;
        for (int i = 0; i < N_GPIO_WR; i++) begin
            apb_write(gpio_base + (addr_t'($random(seed)) & 8'd3), $random(seed),
                      strb_t'($random(seed)));
            check_gpio(gpio_out, shadow_out);
            apb_read(gpio_base + gpio_out_reg);
        end
        apb_read(gpio_base + gpio_in_reg);

        // Error responses leave state alone
        apb_write(gpio_base + gpio_in_reg, $random(seed), 4'hf);
        apb_read(gpio_base + gpio_in_reg);
        apb_read(8'd24);
        apb_write(8'd28, $random(seed), 4'hf);
        apb_read(8'd24 + (addr_t'($random(seed)) % 8'd232));
        check_gpio(gpio_out, shadow_out);

        // Counting rtc edges
        rtc_pulses(N_RTC);
        apb_read(timer_base + mtime_lo);

        // Compare and interrupt
        base = $random(seed) & 32'h0fff_ffff;
        apb_write(timer_base + mtime_hi, '0, 4'hf);
        apb_write(timer_base + mtime_lo, base, 4'hf);
        apb_write(timer_base + mtimecmp_lo, base + 32'd4, 4'hf);
        apb_write(timer_base + mtimecmp_hi, '0, 4'hf);
        check_irq(timer_irq, 1'b0);
        rtc_pulses(3);
        check_irq(timer_irq, 1'b0);
        rtc_pulses(1);
        check_irq(timer_irq, 1'b1);
        rtc_pulses(1);
        check_irq(timer_irq, 1'b1);
        apb_write(timer_base + mtimecmp_lo, base + 32'd16, 4'hf);
        check_irq(timer_irq, 1'b0);

        // 64-bit mtime with a carry into the upper word
        hi_word = $random(seed);
        apb_write(timer_base + mtime_lo, 32'hffff_fffe, 4'hf);
        apb_write(timer_base + mtime_hi, hi_word, 4'hf);
        rtc_pulses(3);
        apb_read(timer_base + mtime_lo);
        apb_read(timer_base + mtime_hi);

        @(negedge aclk);
        if (completed != issued) begin
            $display("Compare process saw %0d transfers but %0d were issued",
                     completed, issued);
            misc_errs++;
        end
        $display("Errors: prdata %0d, pslverr %0d, pready %0d, gpio %0d, irq %0d, other %0d",
                 data_errs, err_errs, ready_errs, gpio_errs, irq_errs, misc_errs);
        if (data_errs + err_errs + ready_errs + gpio_errs + irq_errs + misc_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Run timed out after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/io_apb_fabric.sv
// APB fabric for the IO platform
// Decodes the address, steers the select and returns the target's response

`default_nettype none

module io_apb_fabric
    import io_pkg::*;
(
    // External APB completer port
    input  logic     psel,
    input  logic     penable,
    input  addr_t    paddr,
    input  logic     pwrite,
    input  data_t    pwdata,
    input  strb_t    pstrb,
    output data_t    prdata,
    output logic     pready,
    output logic     pslverr,
    // Peripheral side
    output apb_req_t req,
    output logic     gpio_sel,
    output logic     timer_sel,
    output logic     enable,
    input  apb_rsp_t gpio_rsp,
    input  apb_rsp_t timer_rsp
);

    slave_sel_e target;
    addr_t      gpio_offs;
    addr_t      timer_offs;
    apb_rsp_t   rsp_mux;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Offsets wrap on underflow, so one compare per window suffices
    assign gpio_offs  = paddr - gpio_base;
    assign timer_offs = paddr - timer_base;

    always_comb begin
        if (gpio_offs < gpio_size) begin
            target = sel_gpio;
        end else if (timer_offs < timer_size) begin
            target = sel_timer;
        end else begin
            target = sel_none;
        end
    end

    // Same request goes to both peripherals
    assign req.addr  = paddr;
    assign req.write = pwrite;
    assign req.wdata = pwdata;
    assign req.strb  = pstrb;

    assign gpio_sel  = psel && (target == sel_gpio);
    assign timer_sel = psel && (target == sel_timer);
    assign enable    = penable;

    //////////////////////////////////////////////////////////////////////
    // Response combine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (target)
            sel_gpio:  rsp_mux = gpio_rsp;
            sel_timer: rsp_mux = timer_rsp;
            default: begin
                // Unmapped, complete at once with an error
                rsp_mux.rdata = '0;
                rsp_mux.ready = psel && penable;
                rsp_mux.err   = psel && penable;
            end
        endcase
    end

    assign prdata  = rsp_mux.rdata;
    assign pready  = rsp_mux.ready;
    assign pslverr = rsp_mux.err;

endmodule

`default_nettype wire

// File: source/io_gpio.sv
// GPIO peripheral
// Byte-writable output register and a sampled input port

`default_nettype none

module io_gpio
    import io_pkg::*;
#(
    parameter int GPIO_W = 32
)(
    input  logic              aclk,
    input  logic              reset,
    input  logic              sel,
    input  logic              enable,
    input  apb_req_t          req,
    output apb_rsp_t          rsp,
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out
);

    addr_t             offset;
    addr_t             reg_sel;
    logic              access;
    logic              out_wr;
    logic              in_wr;
    logic [GPIO_W-1:0] gpio_out_q;
    logic [GPIO_W-1:0] gpio_in_q;
    data_t             out_ext;
    data_t             out_next;
    data_t             rd_value;

    assign offset  = req.addr - gpio_base;
    // Word aligned register select
    assign reg_sel = offset & ~addr_t'(3);
    assign access  = sel && enable;
    assign out_wr  = access && req.write && (reg_sel == gpio_out_reg);
    assign in_wr   = access && req.write && (reg_sel == gpio_in_reg);

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    assign out_ext  = data_t'(gpio_out_q);
    assign out_next = apply_strb(out_ext, req.wdata, req.strb);

    always_ff @(posedge aclk) begin
        if (reset) begin
            gpio_out_q <= '0;
        end else if (out_wr) begin
            gpio_out_q <= out_next[GPIO_W-1:0];
        end
    end

    // Input sampled every cycle
    always_ff @(posedge aclk) begin
        gpio_in_q <= gpio_in;
    end

    assign gpio_out = gpio_out_q;

    //////////////////////////////////////////////////////////////////////
    // Response, completes in the first access cycle
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_sel)
            gpio_out_reg: rd_value = out_ext;
            gpio_in_reg:  rd_value = data_t'(gpio_in_q);
            default:      rd_value = '0;
        endcase
    end

    assign rsp.rdata = (access && !req.write) ? rd_value : '0;
    assign rsp.ready = access;
    assign rsp.err   = in_wr;

endmodule

`default_nettype wire

// File: source/io_pkg.sv
// IO platform shared definitions
// Bus types, address map, register offsets and state encodings

`default_nettype none

package io_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN = 32;

    typedef logic [7:0]        addr_t;
    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN/8-1:0] strb_t;

    // One transfer as forwarded by the fabric
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t strb;
    } apb_req_t;

    // One completer response
    typedef struct packed {
        data_t rdata;
        logic  ready;
        logic  err;
    } apb_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // Address map and register offsets
    //////////////////////////////////////////////////////////////////////

    localparam addr_t gpio_base  = 8'd0;
    localparam addr_t gpio_size  = 8'd8;
    localparam addr_t timer_base = 8'd8;
    localparam addr_t timer_size = 8'd16;

    typedef enum logic [1:0] {sel_gpio, sel_timer, sel_none} slave_sel_e;

    typedef enum addr_t {
        gpio_out_reg = 8'd0,
        gpio_in_reg  = 8'd4
    } gpio_reg_e;

    // Offsets relative to timer_base
    typedef enum addr_t {
        mtime_lo    = 8'd0,
        mtime_hi    = 8'd4,
        mtimecmp_lo = 8'd8,
        mtimecmp_hi = 8'd12
    } timer_reg_e;

    typedef enum logic {idle, wait_state} timer_state_e;

    // Byte lane merge under write strobes
    function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
        data_t result;
        result = old_val;
        for (int i = 0; i < XLEN/8; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: source/io_platform.sv
// IO platform top level
// APB fabric in front of the GPIO and machine timer peripherals

`default_nettype none

module io_platform
    import io_pkg::*;
#(
    parameter int GPIO_W          = 32,
    parameter int RTC_SYNC_STAGES = 2
)(
    input  logic              aclk,
    input  logic              reset,
    // APB completer port
    input  logic              psel,
    input  logic              penable,
    input  addr_t             paddr,
    input  logic              pwrite,
    input  data_t             pwdata,
    input  strb_t             pstrb,
    output data_t             prdata,
    output logic              pready,
    output logic              pslverr,
    // Real-time reference clock
    input  logic              rtc,
    // GPIO pins
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic              timer_irq
);

    apb_req_t req;
    apb_rsp_t gpio_rsp;
    apb_rsp_t timer_rsp;
    logic     gpio_sel;
    logic     timer_sel;
    logic     enable;

    ///////////////////////////////////////////////////////////////////////
    // Instances
    ///////////////////////////////////////////////////////////////////////

    io_apb_fabric fabric (
        .psel      (psel),
        .penable   (penable),
        .paddr     (paddr),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req       (req),
        .gpio_sel  (gpio_sel),
        .timer_sel (timer_sel),
        .enable    (enable),
        .gpio_rsp  (gpio_rsp),
        .timer_rsp (timer_rsp)
    );

    io_gpio #(
        .GPIO_W (GPIO_W)
    ) gpio (
        .aclk     (aclk),
        .reset    (reset),
        .sel      (gpio_sel),
        .enable   (enable),
        .req      (req),
        .rsp      (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    io_timer #(
        .RTC_SYNC_STAGES (RTC_SYNC_STAGES)
    ) timer (
        .aclk      (aclk),
        .reset     (reset),
        .sel       (timer_sel),
        .enable    (enable),
        .req       (req),
        .rsp       (timer_rsp),
        .rtc       (rtc),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// File: source/io_timer.sv
// Machine timer peripheral
// Counts rtc rising edges into mtime and flags mtime >= mtimecmp

`default_nettype none

module io_timer
    import io_pkg::*;
#(
    parameter int RTC_SYNC_STAGES = 2
)(
    input  logic     aclk,
    input  logic     reset,
    input  logic     sel,
    input  logic     enable,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    input  logic     rtc,
    output logic     timer_irq
);

    logic [RTC_SYNC_STAGES-1:0] rtc_sync;
    logic                       rtc_last;
    logic                       rtc_rise;

    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;

    timer_state_e state;
    addr_t        offset;
    addr_t        reg_sel;
    logic         access;
    logic         wr_en;
    data_t        rd_value;
    data_t        rdata_q;

    //////////////////////////////////////////////////////////////////////
    // rtc synchronizer and edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            rtc_sync <= '0;
            rtc_last <= 1'b0;
        end else begin
            rtc_sync <= {rtc_sync[RTC_SYNC_STAGES-2:0], rtc};
            rtc_last <= rtc_sync[RTC_SYNC_STAGES-1];
        end
    end

    assign rtc_rise = rtc_sync[RTC_SYNC_STAGES-1] && !rtc_last;

    //////////////////////////////////////////////////////////////////////
    // Access FSM with one wait state
    //////////////////////////////////////////////////////////////////////

    assign offset  = req.addr - timer_base;
    assign reg_sel = offset & ~addr_t'(3);
    assign access  = sel && enable;

    // Write lands in the completing cycle
    assign wr_en = access && req.write && (state == wait_state);

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle:       if (access) state <= wait_state;
                wait_state: state <= idle;
                default:    state <= idle;
            endcase
        end
    end

    always_comb begin
        case (reg_sel)
            mtime_lo:    rd_value = mtime[31:0];
            mtime_hi:    rd_value = mtime[63:32];
            mtimecmp_lo: rd_value = mtimecmp[31:0];
            mtimecmp_hi: rd_value = mtimecmp[63:32];
            default:     rd_value = '0;
        endcase
    end

    // Read data captured at the end of the first access cycle
    always_ff @(posedge aclk) begin
        if (access && state == idle) begin
            rdata_q <= req.write ? '0 : rd_value;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.ready = access && (state == wait_state);
    assign rsp.err   = 1'b0;

    //////////////////////////////////////////////////////////////////////
    // Counter and compare registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            // A write to mtime wins over the increment
            if (wr_en && reg_sel == mtime_lo) begin
                mtime[31:0] <= apply_strb(mtime[31:0], req.wdata, req.strb);
            end else if (wr_en && reg_sel == mtime_hi) begin
                mtime[63:32] <= apply_strb(mtime[63:32], req.wdata, req.strb);
            end else if (rtc_rise) begin
                mtime <= mtime + 64'd1;
            end

            if (wr_en && reg_sel == mtimecmp_lo) begin
                mtimecmp[31:0] <= apply_strb(mtimecmp[31:0], req.wdata, req.strb);
            end
            if (wr_en && reg_sel == mtimecmp_hi) begin
                mtimecmp[63:32] <= apply_strb(mtimecmp[63:32], req.wdata, req.strb);
            end
        end
    end

    assign timer_irq = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// File: src.f
source/io_pkg.sv
source/io_apb_fabric.sv
source/io_gpio.sv
source/io_timer.sv
source/io_platform.sv
sim/io_platform_tb.sv
